// ==== flist.f ====
+incdir+design
design/apb_pkg.sv
design/regbank_pkg.sv
design/skid_buffer.sv
design/apb_slave.sv
design/reg_bank.sv
design/apb_reg_subsys.sv
verif/tb_apb_reg_subsys.sv

// ==== Makefile ====
TOP := tb_apb_reg_subsys

.PHONY: sim clean

sim:
	verilator --binary --timing -f flist.f --top-module $(TOP) -o $(TOP)
	@out="$$(./obj_dir/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TESTBENCH PASSED"

clean:
	rm -rf obj_dir

// ==== verif/tb_apb_reg_subsys.sv ====
`timescale 1ns/1ps

`include "apb_defs.svh"

module tb_apb_reg_subsys
        import apb_pkg::*;
();

        localparam int TIMEOUT = 50;

        logic  pclk;
        logic  rst_n;
        logic  psel;
        logic  penable;
        logic  pwrite;
        addr_t paddr;
        data_t pwdata;
        strb_t pstrb;
        prot_t pprot;
        logic  pready;
        data_t prdata;
        logic  pslverr;

        // Expected register contents
        data_t       model [`REG_COUNT];
        logic [31:0] lcg_state;
        int          pass_count;
        int          fail_count;
        int          fails_at_start;

        apb_reg_subsys uut (
                .pclk    (pclk),
                .rst_n   (rst_n),
                .psel    (psel),
                .penable (penable),
                .pwrite  (pwrite),
                .paddr   (paddr),
                .pwdata  (pwdata),
                .pstrb   (pstrb),
                .pprot   (pprot),
                .pready  (pready),
                .prdata  (prdata),
                .pslverr (pslverr)
        );

        initial begin
                pclk = 1'b0;
                forever #5 pclk = ~pclk;
        end

        // Upper halves of two LCG steps since the low bits repeat quickly
        function automatic logic [31:0] lcg_next();
                logic [15:0] hi;
                lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
                hi = lcg_state[31:16];
                lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
                return {hi, lcg_state[31:16]};
        endfunction

        // Out of range, misaligned, or a write to the ID register
        function automatic logic addr_error(input addr_t addr, input logic write);
                return (|addr[`APB_AW-1:5]) || (|addr[1:0]) || (write && addr[4:2] == 3'd7);
        endfunction

        function automatic data_t merge_bytes(input data_t old, input data_t wdata,
                                              input strb_t strb);
                data_t res;
                res = old;
                for (int b = 0; b < `APB_SW; b++) begin
                        if (strb[b]) begin
                                res[8*b +: 8] = wdata[8*b +: 8];
                        end
                end
                return res;
        endfunction

        task automatic check(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
                if (actual !== expected) begin
                        $display("CHECK FAILED at %0t ns: %s actual=%h expected=%h",
                                 $time, name, actual, expected);
                        fail_count++;
                end else begin
                        pass_count++;
                end
        endtask

        // Setup and access phases followed by polling pready on falling edges
        task automatic transfer(input logic write, input addr_t addr, input data_t wdata,
                                input strb_t strb, output data_t rdata, output logic err);
                int cycles;
                psel    = 1'b1;
                penable = 1'b0;
                pwrite  = write;
                paddr   = addr;
                pwdata  = wdata;
                pstrb   = write ? strb : '0;
                pprot   = prot_t'(lcg_next() >> 29);
                @(negedge pclk);
                penable = 1'b1;
                @(negedge pclk);
                cycles = 1;
                while (pready !== 1'b1 && cycles < TIMEOUT) begin
                        @(negedge pclk);
                        cycles++;
                end
                if (pready === 1'b1) begin
                        rdata   = prdata;
                        err     = pslverr;
                        psel    = 1'b0;
                        penable = 1'b0;
                end else begin
                        $display("Timeout: no pready within %0d cycles for %s at address %h",
                                 TIMEOUT, write ? "write" : "read", addr);
                        fail_count++;
                        $display("TESTBENCH FAILED");
                        $finish;
                end
        endtask

        task automatic apb_write(input addr_t addr, input data_t data, input strb_t strb,
                                 output data_t rdata, output logic err);
                transfer(1'b1, addr, data, strb, rdata, err);
        endtask

        task automatic apb_read(input addr_t addr, output data_t data, output logic err);
                transfer(1'b0, addr, '0, '0, data, err);
        endtask

        task automatic write_checked(input addr_t addr, input data_t data, input strb_t strb);
                data_t rdata;
                logic  err;
                logic  exp_err;
                exp_err = addr_error(addr, 1'b1);
                apb_write(addr, data, strb, rdata, err);
                check($sformatf("pslverr @%h", addr), 32'(err), 32'(exp_err));
                // A rejected access returns zero data
                if (exp_err) begin
                        check($sformatf("prdata @%h", addr), rdata, 32'd0);
                end else begin
                        model[addr[4:2]] = merge_bytes(model[addr[4:2]], data, strb);
                end
        endtask

        task automatic read_checked(input addr_t addr);
                data_t rdata;
                logic  err;
                logic  exp_err;
                data_t exp_data;
                exp_err  = addr_error(addr, 1'b0);
                exp_data = exp_err ? '0 : model[addr[4:2]];
                apb_read(addr, rdata, err);
                check($sformatf("prdata @%h", addr), rdata, exp_data);
                check($sformatf("pslverr @%h", addr), 32'(err), 32'(exp_err));
        endtask

        task automatic end_test(input string name);
                $display("%s: done, %0d failed checks", name, fail_count - fails_at_start);
                fails_at_start = fail_count;
        endtask

        initial begin
                addr_t       addr;
                logic [31:0] r;
                lcg_state      = 32'd97067;
                pass_count     = 0;
                fail_count     = 0;
                fails_at_start = 0;
                rst_n   = 1'b0;
                psel    = 1'b0;
                penable = 1'b0;
                pwrite  = 1'b0;
                paddr   = '0;
                pwdata  = '0;
                pstrb   = '0;
                pprot   = '0;
                for (int k = 0; k < `REG_COUNT; k++) begin
                        model[k] = '0;
                end
                model[`REG_COUNT-1] = `REG_ID_VALUE;
                repeat (2) @(negedge pclk);
                rst_n = 1'b1;
                @(negedge pclk);

                check("pready", 32'(pready), 32'd0);
                check("pslverr", 32'(pslverr), 32'd0);
                for (int k = 0; k < 7; k++) begin
                        read_checked(addr_t'(k * 4));
                end
                end_test("reset values");

                for (int k = 0; k < 20; k++) begin
                        addr = addr_t'((lcg_next() % 7) * 4);
                        write_checked(addr, lcg_next(), '1);
                        read_checked(addr);
                end
                end_test("full strobe writes");

                for (int k = 0; k < 20; k++) begin
                        addr = addr_t'((lcg_next() % 7) * 4);
                        write_checked(addr, lcg_next(), strb_t'(lcg_next() >> 28));
                        read_checked(addr);
                end
                end_test("partial strobe writes");

                read_checked(addr_t'(28));
                write_checked(addr_t'(28), lcg_next(), '1);
                read_checked(addr_t'(28));
                end_test("id register");

                for (int k = 0; k < 12; k++) begin
                        r = lcg_next();
                        if (r[31]) begin
                                addr = (addr_t'(lcg_next()) | 12'h020) & 12'hFFC;
                        end else begin
                                addr = addr_t'((lcg_next() % 8) * 4 + 1 + lcg_next() % 3);
                        end
                        if (r[30]) begin
                                write_checked(addr, lcg_next(), '1);
                        end else begin
                                read_checked(addr);
                        end
                end
                for (int k = 0; k < `REG_COUNT; k++) begin
                        read_checked(addr_t'(k * 4));
                end
                end_test("bad addresses");

                // Mostly legal word addresses with some fully random ones
                for (int k = 0; k < 200; k++) begin
                        r = lcg_next();
                        if (r[31:29] != 3'd0) begin
                                addr = addr_t'({r[28:26], 2'b00});
                        end else begin
                                addr = addr_t'(lcg_next());
                        end
                        if (r[25]) begin
                                write_checked(addr, lcg_next(), strb_t'(r[24:21]));
                        end else begin
                                read_checked(addr);
                        end
                        repeat (int'(r[20:19])) @(negedge pclk);
                end
                end_test("random traffic");

                $display("checks passed: %0d, checks failed: %0d", pass_count, fail_count);
                if (fail_count == 0) begin
                        $display("TESTBENCH PASSED");
                end else begin
                        $display("TESTBENCH FAILED");
                end
                $finish;
        end

endmodule : tb_apb_reg_subsys

// ==== design/apb_reg_subsys.sv ====
`timescale 1ns/1ps

`include "apb_defs.svh"

module apb_reg_subsys
        import apb_pkg::*;
(
        input  logic  pclk,
        input  logic  rst_n,
        input  logic  psel,
        input  logic  penable,
        input  logic  pwrite,
        input  addr_t paddr,
        input  data_t pwdata,
        input  strb_t pstrb,
        input  prot_t pprot,
        output logic  pready,
        output data_t prdata,
        output logic  pslverr
);

        // Command path
        logic  cmd_valid;
        logic  cmd_ready;
        logic  cmd_pwrite;
        addr_t cmd_paddr;
        data_t cmd_pwdata;
        strb_t cmd_pstrb;
        prot_t cmd_pprot;

        // Response path
        logic  rsp_valid;
        logic  rsp_ready;
        data_t rsp_prdata;
        logic  rsp_pslverr;

        apb_slave slave_inst (
                .pclk        (pclk),
                .rst_n       (rst_n),
                .psel        (psel),
                .penable     (penable),
                .pwrite      (pwrite),
                .paddr       (paddr),
                .pwdata      (pwdata),
                .pstrb       (pstrb),
                .pprot       (pprot),
                .pready      (pready),
                .prdata      (prdata),
                .pslverr     (pslverr),
                .cmd_valid   (cmd_valid),
                .cmd_ready   (cmd_ready),
                .cmd_pwrite  (cmd_pwrite),
                .cmd_paddr   (cmd_paddr),
                .cmd_pwdata  (cmd_pwdata),
                .cmd_pstrb   (cmd_pstrb),
                .cmd_pprot   (cmd_pprot),
                .rsp_valid   (rsp_valid),
                .rsp_ready   (rsp_ready),
                .rsp_prdata  (rsp_prdata),
                .rsp_pslverr (rsp_pslverr)
        );

        reg_bank bank_inst (
                .pclk        (pclk),
                .rst_n       (rst_n),
                .cmd_valid   (cmd_valid),
                .cmd_ready   (cmd_ready),
                .cmd_pwrite  (cmd_pwrite),
                .cmd_paddr   (cmd_paddr),
                .cmd_pwdata  (cmd_pwdata),
                .cmd_pstrb   (cmd_pstrb),
                .cmd_pprot   (cmd_pprot),
                .rsp_valid   (rsp_valid),
                .rsp_ready   (rsp_ready),
                .rsp_prdata  (rsp_prdata),
                .rsp_pslverr (rsp_pslverr)
        );

endmodule : apb_reg_subsys

// ==== design/reg_bank.sv ====
`timescale 1ns/1ps

`include "apb_defs.svh"

module reg_bank
        import apb_pkg::*;
        import regbank_pkg::*;
(
        input  logic  pclk,
        input  logic  rst_n,

        input  logic  cmd_valid,
        output logic  cmd_ready,
        input  logic  cmd_pwrite,
        input  addr_t cmd_paddr,
        input  data_t cmd_pwdata,
        input  strb_t cmd_pstrb,
        // PPROT arrives with the command but no access depends on it
        input  prot_t cmd_pprot,

        output logic  rsp_valid,
        input  logic  rsp_ready,
        output data_t rsp_prdata,
        output logic  rsp_pslverr
);

        localparam reg_idx_t ID_IDX = reg_idx_t'(`REG_COUNT - 1);

        data_t    regs [`REG_COUNT-1];
        reg_idx_t idx;
        logic     err;
        logic     accept;
        data_t    rd_word;

        assign idx = cmd_paddr[4:2];

        // Out of range, misaligned, or a write to the ID register
        assign err = (|cmd_paddr[`APB_AW-1:5]) || (|cmd_paddr[1:0]) ||
                     (cmd_pwrite && (idx == ID_IDX));

        // One response register, so take a command only when it is free
        assign cmd_ready = !rsp_valid;
        assign accept    = cmd_valid && cmd_ready;

        always_comb begin
                rd_word = `REG_ID_VALUE;
                for (int i = 0; i < `REG_COUNT - 1; i++) begin
                        if (idx == reg_idx_t'(i)) begin
                                rd_word = regs[i];
                        end
                end
        end

        always_ff @(posedge pclk or negedge rst_n) begin
                if (!rst_n) begin
                        for (int i = 0; i < `REG_COUNT - 1; i++) begin
                                regs[i] <= '0;
                        end
                        rsp_valid   <= 1'b0;
                        rsp_prdata  <= '0;
                        rsp_pslverr <= 1'b0;
                end else if (accept) begin
                        rsp_valid   <= 1'b1;
                        rsp_pslverr <= err;
                        rsp_prdata  <= (err || cmd_pwrite) ? '0 : rd_word;
                        // Byte-lane merge on a good write
                        if (cmd_pwrite && !err) begin
                                for (int i = 0; i < `REG_COUNT - 1; i++) begin
                                        for (int b = 0; b < `APB_SW; b++) begin
                                                if (idx == reg_idx_t'(i) && cmd_pstrb[b]) begin
                                                        regs[i][8*b +: 8] <= cmd_pwdata[8*b +: 8];
                                                end
                                        end
                                end
                        end
                end else if (rsp_valid && rsp_ready) begin
                        rsp_valid <= 1'b0;
                end
        end

endmodule : reg_bank

// ==== design/apb_slave.sv ====
`timescale 1ns/1ps

`include "apb_defs.svh"

module apb_slave
        import apb_pkg::*;
        import regbank_pkg::*;
(
        input  logic  pclk,
        input  logic  rst_n,

        // APB completer side
        input  logic  psel,
        input  logic  penable,
        input  logic  pwrite,
        input  addr_t paddr,
        input  data_t pwdata,
        input  strb_t pstrb,
        input  prot_t pprot,
        output logic  pready,
        output data_t prdata,
        output logic  pslverr,

        // Command packet out
        output logic  cmd_valid,
        input  logic  cmd_ready,
        output logic  cmd_pwrite,
        output addr_t cmd_paddr,
        output data_t cmd_pwdata,
        output strb_t cmd_pstrb,
        output prot_t cmd_pprot,

        // Response packet in
        input  logic  rsp_valid,
        output logic  rsp_ready,
        input  data_t rsp_prdata,
        input  logic  rsp_pslverr
);

        localparam int CPW = 1 + `APB_PW + `APB_SW + `APB_AW + `APB_DW;
        localparam int RPW = 1 + `APB_DW;

        logic           cmd_wr_valid;
        logic           cmd_wr_ready;
        logic [CPW-1:0] cmd_word;
        logic [CPW-1:0] cmd_rd_data;

        logic           rsp_rd_valid;
        logic           rsp_rd_ready;
        logic [RPW-1:0] rsp_rd_data;
        cnt_t           rsp_count;
        data_t          rsp_word_data;
        logic           rsp_word_err;

        apb_state_t     state;
        logic           penable_q;
        logic           start;

        // First access cycle of a transfer, with room downstream and no stale response
        assign start = (state == IDLE) && psel && penable && !penable_q &&
                       cmd_wr_ready && (rsp_count == '0);

        // Command word captured once per transfer
        always_ff @(posedge pclk) begin
                if (start) begin
                        cmd_word <= {pwrite, pprot, pstrb, paddr, pwdata};
                end
        end

        skid_buffer #(
                .DEPTH      (`SKID_DEPTH),
                .DATA_WIDTH (CPW)
        ) cmd_skid (
                .pclk     (pclk),
                .rst_n    (rst_n),
                .wr_valid (cmd_wr_valid),
                .wr_ready (cmd_wr_ready),
                .wr_data  (cmd_word),
                .rd_valid (cmd_valid),
                .rd_ready (cmd_ready),
                .rd_data  (cmd_rd_data),
                .count    ()
        );

        assign {cmd_pwrite, cmd_pprot, cmd_pstrb, cmd_paddr, cmd_pwdata} = cmd_rd_data;

        skid_buffer #(
                .DEPTH      (`SKID_DEPTH),
                .DATA_WIDTH (RPW)
        ) rsp_skid (
                .pclk     (pclk),
                .rst_n    (rst_n),
                .wr_valid (rsp_valid),
                .wr_ready (rsp_ready),
                .wr_data  ({rsp_pslverr, rsp_prdata}),
                .rd_valid (rsp_rd_valid),
                .rd_ready (rsp_rd_ready),
                .rd_data  (rsp_rd_data),
                .count    (rsp_count)
        );

        assign {rsp_word_err, rsp_word_data} = rsp_rd_data;

        always_ff @(posedge pclk or negedge rst_n) begin
                if (!rst_n) begin
                        state        <= IDLE;
                        pready       <= 1'b0;
                        pslverr      <= 1'b0;
                        prdata       <= '0;
                        cmd_wr_valid <= 1'b0;
                        rsp_rd_ready <= 1'b0;
                        penable_q    <= 1'b0;
                end else begin
                        // Single-cycle pulses by default, prdata holds
                        pready       <= 1'b0;
                        pslverr      <= 1'b0;
                        cmd_wr_valid <= 1'b0;
                        rsp_rd_ready <= 1'b0;
                        penable_q    <= penable;

                        case (state)
                                IDLE: begin
                                        if (start) begin
                                                cmd_wr_valid <= 1'b1;
                                                state        <= BUSY;
                                        end
                                end
                                BUSY: begin
                                        if (rsp_rd_valid) begin
                                                pready       <= 1'b1;
                                                prdata       <= rsp_word_data;
                                                pslverr      <= rsp_word_err;
                                                rsp_rd_ready <= 1'b1;
                                                state        <= WAIT;
                                        end
                                end
                                // Master drops penable here
                                WAIT:    state <= IDLE;
                                default: state <= IDLE;
                        endcase
                end
        end

endmodule : apb_slave

// ==== design/skid_buffer.sv ====
`timescale 1ns/1ps

`include "apb_defs.svh"

module skid_buffer
        import regbank_pkg::*;
#(
        parameter int DEPTH      = `SKID_DEPTH,
        parameter int DATA_WIDTH = 32
) (
        input  logic                  pclk,
        input  logic                  rst_n,
        input  logic                  wr_valid,
        output logic                  wr_ready,
        input  logic [DATA_WIDTH-1:0] wr_data,
        output logic                  rd_valid,
        input  logic                  rd_ready,
        output logic [DATA_WIDTH-1:0] rd_data,
        output cnt_t                  count
);

        localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
        localparam logic [PTR_W-1:0] LAST = PTR_W'(DEPTH - 1);

        logic [DATA_WIDTH-1:0] mem [DEPTH];
        logic [PTR_W-1:0]      wr_ptr;
        logic [PTR_W-1:0]      rd_ptr;
        logic                  do_write;
        logic                  do_read;

        // Flags follow the occupancy count
        assign wr_ready = (count != cnt_t'(DEPTH));
        assign rd_valid = (count != '0);

        assign do_write = wr_valid && wr_ready;
        assign do_read  = rd_valid && rd_ready;

        // Head of queue is always visible
        assign rd_data = mem[rd_ptr];

        always_ff @(posedge pclk) begin
                if (do_write) begin
                        mem[wr_ptr] <= wr_data;
                end
        end

        always_ff @(posedge pclk or negedge rst_n) begin
                if (!rst_n) begin
                        wr_ptr <= '0;
                        rd_ptr <= '0;
                        count  <= '0;
                end else begin
                        if (do_write) begin
                                wr_ptr <= (wr_ptr == LAST) ? '0 : wr_ptr + 1'b1;
                        end
                        if (do_read) begin
                                rd_ptr <= (rd_ptr == LAST) ? '0 : rd_ptr + 1'b1;
                        end
                        // Push and pop together leave the count alone
                        case ({do_write, do_read})
                                2'b10:   count <= count + 1'b1;
                                2'b01:   count <= count - 1'b1;
                                default: count <= count;
                        endcase
                end
        end

endmodule : skid_buffer

// ==== design/regbank_pkg.sv ====
`include "apb_defs.svh"

package regbank_pkg;

        // Word index into the register bank
        typedef logic [$clog2(`REG_COUNT)-1:0] reg_idx_t;

        // Buffer occupancy
        typedef logic [3:0] cnt_t;

        // Completer FSM, one-hot
        typedef enum logic [2:0] {
                IDLE = 3'b001,
                BUSY = 3'b010,
                WAIT = 3'b100
        } apb_state_t;

endpackage : regbank_pkg

// ==== design/apb_pkg.sv ====
`include "apb_defs.svh"

package apb_pkg;

        // Address as seen on PADDR
        typedef logic [`APB_AW-1:0] addr_t;

        // PWDATA and PRDATA
        typedef logic [`APB_DW-1:0] data_t;

        // One strobe per byte lane
        typedef logic [`APB_SW-1:0] strb_t;

        // PPROT field
        typedef logic [`APB_PW-1:0] prot_t;

endpackage : apb_pkg

// ==== design/apb_defs.svh ====
`ifndef APB_DEFS_SVH
`define APB_DEFS_SVH

// APB bus widths
`define APB_AW 12
`define APB_DW 32
`define APB_SW (`APB_DW / 8)
`define APB_PW 3

// Register bank size
`define REG_COUNT 8

// Entries in each command and response buffer
`define SKID_DEPTH 2

// Read-only value at the last register index
`define REG_ID_VALUE 32'h5A5A_0001

`endif
